// File: list.f
+incdir+hw
+incdir+verification
hw/minmax_slice_pkg.sv
hw/stage_if.sv
hw/operand_stage.sv
hw/fp_minmax_lane.sv
hw/result_pack_stage.sv
hw/minmax_slice_top.sv
verification/minmax_slice_tb.sv

// File: verification/minmax_ref_model.svh
`ifndef MINMAX_REF_MODEL_SVH
`define MINMAX_REF_MODEL_SVH

// Values are left-aligned, an FP16 value sits in bits 31:16 with zeros below

function automatic logic nan_value(input logic [31:0] v, input logic fp32);
  if (fp32) begin
    return (v[30:23] == 8'hff) && (v[22:0] != 0);
  end
  return (v[30:26] == 5'h1f) && (v[25:16] != 0);
endfunction

// Signaling when the top mantissa bit is clear
function automatic logic signaling_nan(input logic [31:0] v, input logic fp32);
  return nan_value(v, fp32) && !(fp32 ? v[22] : v[25]);
endfunction

// Unsigned key in the same order as the values, so -0 lands just below +0
function automatic logic [31:0] order_key(input logic [31:0] v);
  return v[31] ? ~v : {1'b1, v[30:0]};
endfunction

// One lane, returns {invalid, result}
function automatic logic [32:0] pick_minmax(input logic [31:0] a, input logic [31:0] b,
                                            input logic is_max, input logic fp32);
  logic        inv;
  logic [31:0] res;
  inv = signaling_nan(a, fp32) || signaling_nan(b, fp32);
  if (nan_value(a, fp32) && nan_value(b, fp32)) begin
    res = fp32 ? 32'h7fc0_0000 : 32'h7e00_0000;
  end else if (nan_value(a, fp32)) begin
    res = b;
  end else if (nan_value(b, fp32)) begin
    res = a;
  end else begin
    res = ((order_key(a) > order_key(b)) == is_max) ? a : b;
  end
  return {inv, res};
endfunction

// Whole word for one operation, returns {invalid, result}
function automatic logic [32:0] expected_output(input logic [31:0] a, input logic [31:0] b,
                                                input logic is_max, input logic fp16,
                                                input logic vec, input logic [1:0] mask);
  logic [32:0] lo;
  logic [32:0] hi;
  logic [15:0] a_lo;
  logic [15:0] b_lo;
  if (!fp16) begin
    lo = pick_minmax(a, b, is_max, 1'b1);
    return {lo[32] & mask[0], lo[31:0]};
  end
  // Scalar operand with a broken box reads as the canonical NaN
  a_lo = (vec || (&a[31:16])) ? a[15:0] : 16'h7e00;
  b_lo = (vec || (&b[31:16])) ? b[15:0] : 16'h7e00;
  lo   = pick_minmax({a_lo, 16'h0000}, {b_lo, 16'h0000}, is_max, 1'b0);
  hi   = pick_minmax({a[31:16], 16'h0000}, {b[31:16], 16'h0000}, is_max, 1'b0);
  if (vec) begin
    return {(lo[32] & mask[0]) | (hi[32] & mask[1]), hi[31:16], lo[31:16]};
  end
  return {lo[32] & mask[0], 16'hffff, lo[31:16]};
endfunction

`endif

// File: verification/minmax_slice_tb.sv
`include "minmax_slice_config.svh"

module minmax_slice_tb;

  localparam int num_directed  = 9;
  localparam int num_stream    = 40;
  localparam int num_random    = 150;
  localparam int num_flush     = 3;
  localparam int timeout_limit = 4 * (num_directed + num_stream + num_random + num_flush) + 100;

  typedef struct packed {
    logic                    inv;
    logic [`SLICE_WIDTH-1:0] word;
    logic [`TAG_WIDTH-1:0]   tag;
    logic [31:0]             cycle;
  } expect_t;

  logic                         clk;
  logic                         rst_n;
  logic [`SLICE_WIDTH-1:0]      operand_a;
  logic [`SLICE_WIDTH-1:0]      operand_b;
  minmax_slice_pkg::minmax_op_e op;
  minmax_slice_pkg::fp_fmt_e    fmt;
  logic                         vectorial;
  logic [`NUM_LANES-1:0]        simd_mask;
  logic [`TAG_WIDTH-1:0]        tag_in;
  logic                         in_valid;
  logic                         in_ready;
  logic                         flush;
  logic [`SLICE_WIDTH-1:0]      result;
  logic                         invalid;
  logic [`TAG_WIDTH-1:0]        tag_out;
  logic                         out_valid;
  logic                         out_ready;
  logic                         busy;

  logic                         random_ready;
  logic                         check_latency;
  int                           cycle;
  int                           errors;
  int                           results;
  expect_t                      exp_q[$];
  expect_t                      head;

  `include "minmax_ref_model.svh"

  minmax_slice_top minmax_slice_top_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .op_i        (op),
    .fmt_i       (fmt),
    .vectorial_i (vectorial),
    .simd_mask_i (simd_mask),
    .tag_i       (tag_in),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .flush_i     (flush),
    .result_o    (result),
    .invalid_o   (invalid),
    .tag_o       (tag_out),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .busy_o      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------

  // FP16 pool of signed zeros, infinities, quiet and signaling NaNs and random values
  function automatic logic [15:0] half_value();
    logic [15:0] h;
    h = 16'($urandom);
    case ($urandom % 6)
      0: h[14:0] = '0;
      1: h[14:0] = 15'h7c00;
      2: h[14:9] = 6'h3f;
      3: begin
        h[14:9] = 6'h3e;
        h[0]    = 1'b1;
      end
      default: ;
    endcase
    return h;
  endfunction

  function automatic logic [31:0] word_value();
    logic [31:0] w;
    w = $urandom;
    case ($urandom % 6)
      0: w[30:0] = '0;
      1: w[30:0] = 31'h7f80_0000;
      2: w[30:22] = 9'h1ff;
      3: begin
        w[30:22] = 9'h1fe;
        w[0]     = 1'b1;
      end
      default: ;
    endcase
    return w;
  endfunction

  function automatic logic [31:0] make_operand(input logic is_fp16, input logic vec_in);
    if (!is_fp16) begin
      return word_value();
    end
    if (vec_in) begin
      return {half_value(), half_value()};
    end
    // Now and then a scalar half with a broken box
    return {(($urandom % 8) == 0) ? 16'($urandom) : 16'hffff, half_value()};
  endfunction

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic send(input logic [31:0] a, input logic [31:0] b, input logic is_max,
                      input logic is_fp16, input logic vec_in, input logic [1:0] mask_in);
    @(negedge clk);
    operand_a = a;
    operand_b = b;
    op        = minmax_slice_pkg::minmax_op_e'(is_max);
    fmt       = minmax_slice_pkg::fp_fmt_e'(is_fp16);
    vectorial = vec_in;
    simd_mask = mask_in;
    tag_in    = tag_in + 1'b1;
    in_valid  = 1'b1;
    @(posedge clk);
    while (!in_ready) @(posedge clk);
  endtask

  task automatic send_random();
    logic f;
    logic v;
    f = 1'($urandom);
    v = 1'($urandom);
    send(make_operand(f, v), make_operand(f, v), 1'($urandom), f, v, 2'($urandom));
  endtask

  task automatic drain();
    @(negedge clk);
    in_valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic check_output();
    if (exp_q.size() == 0) begin
      errors++;
      $display("Output transfer at %0t with no operation in flight", $time);
    end else begin
      head = exp_q.pop_front();
      results++;
      assert (result === head.word)
        else flag_mismatch($sformatf("result_o %h, expected %h", result, head.word));
      assert (invalid === head.inv)
        else flag_mismatch($sformatf("invalid_o %b, expected %b", invalid, head.inv));
      assert (tag_out === head.tag)
        else flag_mismatch($sformatf("tag_o %h, expected %h", tag_out, head.tag));
      if (check_latency) begin
        assert (cycle - head.cycle == 2)
          else flag_mismatch($sformatf("latency %0d cycles", cycle - head.cycle));
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Scoreboard and handshake monitor on the rising edge
  // --------------------------------------------------------------------------

  always @(negedge clk) begin
    if (random_ready) begin
      out_ready = ($urandom % 4) != 0;
    end
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > timeout_limit) begin
      $display("Timeout after %0d cycles, %0d results still expected", cycle, exp_q.size());
      $display("Something failed");
      $finish;
    end else if (rst_n) begin
      assert (busy == (exp_q.size() != 0))
        else flag_mismatch($sformatf("busy_o %b with %0d in flight", busy, exp_q.size()));
      // Input side stalls only with both stages full and the output blocked
      assert (in_ready == !((exp_q.size() == 2) && !out_ready))
        else flag_mismatch($sformatf("in_ready_o %b with %0d in flight", in_ready, exp_q.size()));
      if (flush) begin
        exp_q.delete();
      end else begin
        if (out_valid && out_ready) begin
          check_output();
        end
        if (in_valid && in_ready) begin
          exp_q.push_back({expected_output(operand_a, operand_b,
                                           op == minmax_slice_pkg::OP_MAX,
                                           fmt == minmax_slice_pkg::FMT_FP16,
                                           vectorial, simd_mask), tag_in, cycle});
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h4814));
    rst_n         = 1'b0;
    operand_a     = '0;
    operand_b     = '0;
    op            = minmax_slice_pkg::OP_MIN;
    fmt           = minmax_slice_pkg::FMT_FP32;
    vectorial     = 1'b0;
    simd_mask     = '0;
    tag_in        = '0;
    in_valid      = 1'b0;
    flush         = 1'b0;
    out_ready     = 1'b1;
    random_ready  = 1'b0;
    check_latency = 1'b1;
    cycle         = 0;
    errors        = 0;
    results       = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    assert (!out_valid && !busy && in_ready)
      else flag_mismatch("handshake outputs not idle after reset");

    // Signed zeros, NaN cases, broken boxes and lane masks
    send(32'h8000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 2'b01);
    send(32'h7fc0_1234, 32'h3f80_0000, 1'b1, 1'b0, 1'b0, 2'b01);
    send(32'h7f80_0001, 32'hc000_0000, 1'b0, 1'b0, 1'b1, 2'b11);
    // Upper half reads as an FP16 signaling NaN, which a scalar FP32 ignores
    send(32'h7d00_0000, 32'hc000_0000, 1'b0, 1'b0, 1'b1, 2'b11);
    send(32'hff80_0001, 32'h7fc0_1234, 1'b1, 1'b0, 1'b0, 2'b01);
    send(32'h1234_3c00, 32'hffff_bc00, 1'b1, 1'b1, 1'b0, 2'b01);
    send(32'hffff_8000, 32'hffff_0000, 1'b1, 1'b1, 1'b0, 2'b01);
    send(32'h7d00_3c00, 32'h4000_c000, 1'b0, 1'b1, 1'b1, 2'b01);
    send(32'h7d00_3c00, 32'h4000_7c01, 1'b1, 1'b1, 1'b1, 2'b10);
    drain();

    // Back-to-back stream with the output always ready
    repeat (num_stream) send_random();
    drain();

    // Random input gaps and random output back-pressure
    check_latency = 1'b0;
    random_ready  = 1'b1;
    repeat (num_random) begin
      if (($urandom % 4) == 0) begin
        @(negedge clk);
        in_valid = 1'b0;
      end
      send_random();
    end
    drain();
    random_ready = 1'b0;

    // Fill both stages, flush, then one clean operation
    @(negedge clk);
    out_ready = 1'b0;
    send_random();
    send_random();
    @(negedge clk);
    in_valid = 1'b0;
    flush    = 1'b1;
    @(negedge clk);
    flush     = 1'b0;
    out_ready = 1'b1;
    repeat (4) @(negedge clk);
    send_random();
    drain();

    $display("Run complete: %0d results checked, %0d errors", results, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: hw/minmax_slice_top.sv
`include "minmax_slice_config.svh"

module minmax_slice_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Operation in
  input  logic [`SLICE_WIDTH-1:0]      operand_a_i,
  input  logic [`SLICE_WIDTH-1:0]      operand_b_i,
  input  minmax_slice_pkg::minmax_op_e op_i,
  input  minmax_slice_pkg::fp_fmt_e    fmt_i,
  input  logic                         vectorial_i,
  input  logic [`NUM_LANES-1:0]        simd_mask_i,
  input  logic [`TAG_WIDTH-1:0]        tag_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  logic                         flush_i,
  // Result out
  output logic [`SLICE_WIDTH-1:0]      result_o,
  output logic                         invalid_o,
  output logic [`TAG_WIDTH-1:0]        tag_o,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output logic                         busy_o
);

  logic [`SLICE_WIDTH-1:0] lane0_result;
  logic [`SLICE_WIDTH-1:0] lane1_result;
  logic                    lane0_invalid;
  logic                    lane1_invalid;

  stage_if stage_bus ();

  operand_stage operand_stage_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .op_i        (op_i),
    .fmt_i       (fmt_i),
    .vectorial_i (vectorial_i),
    .simd_mask_i (simd_mask_i),
    .tag_i       (tag_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .stage_o     (stage_bus.op_src)
  );

  // Lane 0 covers FP32 and the low FP16 half
  fp_minmax_lane #(.lane_index(0)) lane0_inst (
    .stage_i   (stage_bus.lane_view),
    .result_o  (lane0_result),
    .invalid_o (lane0_invalid)
  );

  fp_minmax_lane #(.lane_index(1)) lane1_inst (
    .stage_i   (stage_bus.lane_view),
    .result_o  (lane1_result),
    .invalid_o (lane1_invalid)
  );

  result_pack_stage result_pack_stage_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .stage_i         (stage_bus.op_dst),
    .lane0_result_i  (lane0_result),
    .lane1_result_i  (lane1_result),
    .lane0_invalid_i (lane0_invalid),
    .lane1_invalid_i (lane1_invalid),
    .result_o        (result_o),
    .invalid_o       (invalid_o),
    .out_valid_o     (out_valid_o),
    .tag_o           (tag_o),
    .out_ready_i     (out_ready_i),
    .busy_o          (busy_o)
  );

endmodule

// File: hw/result_pack_stage.sv
`include "minmax_slice_config.svh"

module result_pack_stage (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  stage_if.op_dst                 stage_i,
  input  logic [`SLICE_WIDTH-1:0] lane0_result_i,
  input  logic [`SLICE_WIDTH-1:0] lane1_result_i,
  input  logic                    lane0_invalid_i,
  input  logic                    lane1_invalid_i,
  output logic [`SLICE_WIDTH-1:0] result_o,
  output logic                    invalid_o,
  output logic                    out_valid_o,
  output logic [`TAG_WIDTH-1:0]   tag_o,
  input  logic                    out_ready_i,
  output logic                    busy_o
);

  logic [`SLICE_WIDTH-1:0] packed_result;
  logic [`NUM_LANES-1:0]   lane_invalid;
  logic [`NUM_LANES-1:0]   lane_active;
  logic                    collapsed_invalid;
  logic                    capture;

  // ---------------------------------------------------------------------------
  // Result packing
  // ---------------------------------------------------------------------------

  always_comb begin
    if (stage_i.fmt == minmax_slice_pkg::FMT_FP32) begin
      packed_result = lane0_result_i;
    end else if (stage_i.vectorial) begin
      packed_result = {lane1_result_i[`FP16_WIDTH-1:0], lane0_result_i[`FP16_WIDTH-1:0]};
    end else begin
      // Scalar FP16 gets NaN-boxed
      packed_result = {{(`SLICE_WIDTH-`FP16_WIDTH){1'b1}}, lane0_result_i[`FP16_WIDTH-1:0]};
    end
  end

  // ---------------------------------------------------------------------------
  // Status collapse
  // ---------------------------------------------------------------------------

  assign lane_invalid = {lane1_invalid_i, lane0_invalid_i};

  // Lane 0 always runs, lane 1 only for vector operations
  assign lane_active = {stage_i.vectorial, 1'b1};

  assign collapsed_invalid = |(lane_invalid & lane_active & stage_i.lane_mask);

  // ---------------------------------------------------------------------------
  // Output register
  // ---------------------------------------------------------------------------

  assign stage_i.ready = ~out_valid_o | out_ready_i;
  assign capture       = stage_i.valid & stage_i.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (flush_i) begin
      out_valid_o <= 1'b0;
    end else if (stage_i.ready) begin
      out_valid_o <= stage_i.valid;
    end
  end

  // Held stable until the consumer takes it
  always_ff @(posedge clk_i) begin
    if (capture) begin
      result_o  <= packed_result;
      invalid_o <= collapsed_invalid;
      tag_o     <= stage_i.tag;
    end
  end

  assign busy_o = out_valid_o | stage_i.valid;

endmodule

// File: hw/fp_minmax_lane.sv
`include "minmax_slice_config.svh"

module fp_minmax_lane #(
  parameter int unsigned lane_index = 0
) (
  stage_if.lane_view              stage_i,
  output logic [`SLICE_WIDTH-1:0] result_o,
  output logic                    invalid_o
);

  localparam int unsigned fp32_man_bits = 23;
  localparam int unsigned fp16_man_bits = 10;
  localparam int unsigned pad_bits      = `FP32_WIDTH - `FP16_WIDTH;

  logic                   wide;
  logic [`FP32_WIDTH-1:0] val_a;
  logic [`FP32_WIDTH-1:0] val_b;
  logic                   nan_a;
  logic                   nan_b;
  logic                   sign_a;
  logic                   sign_b;
  logic [`FP32_WIDTH-2:0] mag_a;
  logic [`FP32_WIDTH-2:0] mag_b;
  logic                   a_below_b;
  logic [`FP32_WIDTH-1:0] canon_nan;

  // Lane operand right-aligned, bad boxing reads as the canonical NaN
  function automatic logic [`FP32_WIDTH-1:0] lane_operand(
    input minmax_slice_pkg::operand_word_u word,
    input logic                            box_fail,
    input logic                            fp32_view
  );
    logic [`FP16_WIDTH-1:0] half;
    half = box_fail ? `FP16_QNAN : word.fp16[lane_index];
    return fp32_view ? word.fp32 : {{pad_bits{1'b0}}, half};
  endfunction

  function automatic logic is_nan(input logic [`FP32_WIDTH-1:0] v, input logic fp32_view);
    if (fp32_view) begin
      return (&v[`FP32_WIDTH-2:fp32_man_bits]) && (|v[fp32_man_bits-1:0]);
    end
    return (&v[`FP16_WIDTH-2:fp16_man_bits]) && (|v[fp16_man_bits-1:0]);
  endfunction

  // Only lane 0 ever sees an FP32 operation
  assign wide  = (lane_index == 0) && (stage_i.fmt == minmax_slice_pkg::FMT_FP32);
  assign val_a = lane_operand(stage_i.operand_a, stage_i.box_fail_a, wide);
  assign val_b = lane_operand(stage_i.operand_b, stage_i.box_fail_b, wide);

  // Classification
  assign nan_a  = is_nan(val_a, wide);
  assign nan_b  = is_nan(val_b, wide);
  assign sign_a = wide ? val_a[`FP32_WIDTH-1] : val_a[`FP16_WIDTH-1];
  assign sign_b = wide ? val_b[`FP32_WIDTH-1] : val_b[`FP16_WIDTH-1];
  assign mag_a  = wide ? val_a[`FP32_WIDTH-2:0] : {{pad_bits{1'b0}}, val_a[`FP16_WIDTH-2:0]};
  assign mag_b  = wide ? val_b[`FP32_WIDTH-2:0] : {{pad_bits{1'b0}}, val_b[`FP16_WIDTH-2:0]};

  // Sign-magnitude order, -0 sorts below +0 through the sign test
  always_comb begin
    if (sign_a != sign_b) begin
      a_below_b = sign_a;
    end else if (sign_a) begin
      a_below_b = (mag_a > mag_b);
    end else begin
      a_below_b = (mag_a < mag_b);
    end
  end

  assign canon_nan = wide ? `FP32_QNAN : {{pad_bits{1'b0}}, `FP16_QNAN};

  always_comb begin
    if (nan_a && nan_b) begin
      result_o = canon_nan;
    end else if (nan_a) begin
      result_o = val_b;
    end else if (nan_b) begin
      result_o = val_a;
    end else if ((stage_i.op == minmax_slice_pkg::OP_MIN) == a_below_b) begin
      result_o = val_a;
    end else begin
      result_o = val_b;
    end
  end

  // Quiet bit is the top mantissa bit, clear means signaling
  assign invalid_o = (nan_a & ~(wide ? val_a[fp32_man_bits-1] : val_a[fp16_man_bits-1])) |
                     (nan_b & ~(wide ? val_b[fp32_man_bits-1] : val_b[fp16_man_bits-1]));

endmodule

// File: hw/operand_stage.sv
`include "minmax_slice_config.svh"

module operand_stage (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,
  input  logic [`SLICE_WIDTH-1:0]      operand_a_i,
  input  logic [`SLICE_WIDTH-1:0]      operand_b_i,
  input  minmax_slice_pkg::minmax_op_e op_i,
  input  minmax_slice_pkg::fp_fmt_e    fmt_i,
  input  logic                         vectorial_i,
  input  logic [`NUM_LANES-1:0]        simd_mask_i,
  input  logic [`TAG_WIDTH-1:0]        tag_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  stage_if.op_src                      stage_o
);

  logic is_fp16;
  logic vectorial;
  logic scalar_fp16;
  logic box_fail_a;
  logic box_fail_b;
  logic accept;

  // ---------------------------------------------------------------------------
  // Input decode
  // ---------------------------------------------------------------------------

  assign is_fp16 = (fmt_i == minmax_slice_pkg::FMT_FP16);

  // FP32 fills the whole word, so it never runs vectorial
  assign vectorial   = vectorial_i & is_fp16;
  assign scalar_fp16 = is_fp16 & ~vectorial;

  // A scalar FP16 operand must have an all-ones upper half
  assign box_fail_a = scalar_fp16 & ~(&operand_a_i[`SLICE_WIDTH-1:`FP16_WIDTH]);
  assign box_fail_b = scalar_fp16 & ~(&operand_b_i[`SLICE_WIDTH-1:`FP16_WIDTH]);

  // ---------------------------------------------------------------------------
  // Stage register
  // ---------------------------------------------------------------------------

  // Free when empty or when the pack stage takes the current item
  assign in_ready_o = ~stage_o.valid | stage_o.ready;
  assign accept     = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stage_o.valid <= 1'b0;
    end else if (flush_i) begin
      stage_o.valid <= 1'b0;
    end else if (in_ready_o) begin
      stage_o.valid <= in_valid_i;
    end
  end

  // Payload only loads on a transfer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      stage_o.operand_a  <= operand_a_i;
      stage_o.operand_b  <= operand_b_i;
      stage_o.box_fail_a <= box_fail_a;
      stage_o.box_fail_b <= box_fail_b;
      stage_o.op         <= op_i;
      stage_o.fmt        <= fmt_i;
      stage_o.vectorial  <= vectorial;
      stage_o.lane_mask  <= simd_mask_i;
      stage_o.tag        <= tag_i;
    end
  end

endmodule

// File: hw/stage_if.sv
`include "minmax_slice_config.svh"

interface stage_if;

  // Handshake between the operand stage and the pack stage
  logic                          valid;
  logic                          ready;

  // Registered operation
  minmax_slice_pkg::operand_word_u operand_a;
  minmax_slice_pkg::operand_word_u operand_b;
  logic                          box_fail_a;
  logic                          box_fail_b;
  minmax_slice_pkg::minmax_op_e  op;
  minmax_slice_pkg::fp_fmt_e     fmt;
  logic                          vectorial;  // Already low for FP32
  logic [`NUM_LANES-1:0]         lane_mask;
  logic [`TAG_WIDTH-1:0]         tag;

  modport op_src (
    output valid, operand_a, operand_b, box_fail_a, box_fail_b,
    output op, fmt, vectorial, lane_mask, tag,
    input  ready
  );

  modport lane_view (
    input operand_a, operand_b, box_fail_a, box_fail_b, op, fmt
  );

  modport op_dst (
    input  valid, fmt, vectorial, lane_mask, tag,
    output ready
  );

endinterface

// File: hw/minmax_slice_pkg.sv
`include "minmax_slice_config.svh"

package minmax_slice_pkg;

  // ---------------------------------------------------------------------------
  // Operation encodings
  // ---------------------------------------------------------------------------

  // Operand format, FP32 uses lane 0 only
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fp_fmt_e;

  typedef enum logic {
    OP_MIN = 1'b0,
    OP_MAX = 1'b1
  } minmax_op_e;

  // ---------------------------------------------------------------------------
  // Operand word
  // ---------------------------------------------------------------------------

  // One 32-bit word seen as a single FP32 value or as two FP16 halves
  // Lane 1 sits in the upper half
  typedef union packed {
    logic [`FP32_WIDTH-1:0]                fp32;
    logic [`NUM_LANES-1:0][`FP16_WIDTH-1:0] fp16;
  } operand_word_u;

endpackage

// File: hw/minmax_slice_config.svh
`ifndef MINMAX_SLICE_CONFIG_SVH
`define MINMAX_SLICE_CONFIG_SVH

// Operand and result word
`define SLICE_WIDTH 32

// Format field widths
`define FP32_WIDTH 32
`define FP16_WIDTH 16

// Canonical quiet NaNs
`define FP32_QNAN 32'h7fc0_0000
`define FP16_QNAN 16'h7e00

// SIMD lanes and the tag carried with each operation
`define NUM_LANES 2
`define TAG_WIDTH 4

`endif
